/* wb_cache.f */
logic/cache_pkg.sv
logic/cache_store.sv
logic/cache_ctrl.sv
logic/wb_cache.sv
test/wb_cache_props.sv
test/wb_cache_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f wb_cache.f --top-module wb_cache_tb \
    -o wb_cache_sim &&
{ out=$(./obj_dir/wb_cache_sim); echo "$out"; echo "$out" | grep -q "Simulation passed"; } &&
echo "run_sim: testbench reported success" ||
{ echo "run_sim: build or run did not succeed"; exit 1; }

/* test/wb_cache_tb.sv */
// self-checking testbench for wb_cache with memory model and reference cache model
`timescale 1ns/1ns

module wb_cache_tb;
    import cache_pkg::*;

    logic                   clk;
    logic                   rst_n;
    proc_req_t              proc_req;
    logic [word_width-1:0]  proc_rdata;
    logic                   proc_stall;
    mem_req_t               mem_req;
    logic [block_width-1:0] mem_rdata;
    logic                   mem_ready;

    int          directed_ops = 6;
    int          random_ops   = 200;
    int          cycle        = 0;
    int          done_count   = 0;
    bit          stall_seen   = 1'b0;
    logic [31:0] stim_state   = 32'h5753_0a35;
    logic [31:0] mem_state    = 32'h5753_0a35;

    // requests in flight and memory transfers since the last completion
    proc_req_t              op_queue    [$];
    int                     issue_queue [$];
    mem_req_t               mem_log     [$];
    logic [block_width-1:0] mem_blocks  [logic [block_addr_width-1:0]];

    // reference cache state
    logic [tag_width-1:0]  ref_tag   [way_count][set_count];
    bit                    ref_valid [way_count][set_count];
    bit                    ref_dirty [way_count][set_count];
    bit                    ref_lru   [set_count];
    logic [word_width-1:0] ref_words [logic [word_addr_width-1:0]];

    wb_cache i_wb_cache (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_req   (proc_req),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // memory contents before any write mix in every address bit
    function automatic logic [31:0] init_word(input logic [word_addr_width-1:0] a);
        return {a, 2'b01} ^ 32'h3c5a_9600;
    endfunction

    function automatic logic [block_width-1:0] init_block(input logic [27:0] b);
        logic [block_width-1:0] blk;
        for (int j = 0; j < words_per_block; j++) begin
            blk[j*word_width +: word_width] = init_word({b, j[1:0]});
        end
        return blk;
    endfunction

    function automatic logic [31:0] flat_read(input logic [word_addr_width-1:0] a);
        return ref_words.exists(a) ? ref_words[a] : init_word(a);
    endfunction

    function automatic logic [block_width-1:0] flat_block(input logic [27:0] b);
        logic [block_width-1:0] blk;
        for (int j = 0; j < words_per_block; j++) begin
            blk[j*word_width +: word_width] = flat_read({b, j[1:0]});
        end
        return blk;
    endfunction

    // three tags share every set
    function automatic logic [tag_width-1:0] pool_tag(input logic [1:0] sel);
        case (sel)
            2'd1:    return 26'h155_5555;
            2'd2:    return 26'h2ab_cdef;
            default: return 26'h000_0013;
        endcase
    endfunction

    // expected read data and hit with the victim from the first invalid way else lru
    function automatic logic model_access(input proc_req_t req, output logic [31:0] rd,
                                          output logic evict, output logic [27:0] evict_addr);
        logic [tag_width-1:0]   t;
        logic [index_width-1:0] s;
        logic                   w;
        logic                   hit;
        t          = req.addr[word_addr_width-1:4];
        s          = req.addr[3:2];
        hit        = 1'b0;
        w          = 1'b0;
        evict      = 1'b0;
        evict_addr = '0;
        for (int i = 0; i < way_count; i++) begin
            if (ref_valid[i][s] && ref_tag[i][s] == t) begin
                hit = 1'b1;
                w   = i[0];
            end
        end
        if (!hit) begin
            w          = !ref_valid[0][s] ? 1'b0 : (!ref_valid[1][s] ? 1'b1 : ref_lru[s]);
            evict      = ref_valid[w][s] && ref_dirty[w][s];
            evict_addr = {ref_tag[w][s], s};
            ref_tag[w][s]   = t;
            ref_valid[w][s] = 1'b1;
            ref_dirty[w][s] = 1'b0;
        end
        if (req.write) begin
            ref_words[req.addr] = req.wdata;
            ref_dirty[w][s]     = 1'b1;
        end
        // read hits leave the lru bit alone
        if (!hit || req.write) begin
            ref_lru[s] = !w;
        end
        rd = flat_read(req.addr);
        return hit;
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s (op %0d): expected %0h, actual %0h",
                     name, done_count, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic drive_request(input logic wr, input logic [29:0] a, input logic [31:0] d);
        proc_req_t req;
        req.read  = !wr;
        req.write = wr;
        req.addr  = a;
        req.wdata = d;
        proc_req <= req;
        op_queue.push_back(req);
        issue_queue.push_back(cycle);
        do @(posedge clk); while (!proc_stall);
        do @(posedge clk); while (proc_stall);
    endtask

    // ----------------------------------------
    // compare process
    // ----------------------------------------

    task automatic compare_completion();
        proc_req_t   req;
        mem_req_t    xfer;
        int          issued;
        logic [31:0] exp_rd;
        logic        evict;
        logic [27:0] evict_addr;
        logic        hit;
        req    = op_queue.pop_front();
        issued = issue_queue.pop_front();
        hit    = model_access(req, exp_rd, evict, evict_addr);
        if (req.read) begin
            check_value("read data", exp_rd, proc_rdata);
        end
        if (hit) begin
            check_value("hit latency", 3, cycle - issued - 1);
            check_value("hit memory transfers", 0, mem_log.size());
        end else begin
            check_value("miss memory transfers", evict ? 2 : 1, mem_log.size());
            if (evict) begin
                xfer = mem_log.pop_front();
                check_value("write-back kind", 1, xfer.write);
                check_value("write-back address", evict_addr, xfer.addr);
                check_value("write-back data", flat_block(evict_addr), xfer.wdata);
            end
            xfer = mem_log.pop_front();
            check_value("fill kind", 1, xfer.read);
            check_value("fill address", req.addr[word_addr_width-1:offset_width], xfer.addr);
        end
        done_count++;
    endtask

    always @(posedge clk) begin
        if (rst_n === 1'b1) begin
            if (proc_stall) begin
                stall_seen = 1'b1;
            end else if (stall_seen) begin
                stall_seen = 1'b0;
                compare_completion();
            end
        end
    end

    // ----------------------------------------
    // memory model
    // ----------------------------------------

    initial begin : memory_model
        int delay;
        mem_ready <= 1'b0;
        mem_rdata <= '0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            if (mem_req.read || mem_req.write) begin
                mem_state = lcg_next(mem_state);
                delay     = mem_state[31:16] % 6;
                repeat (delay) @(posedge clk);
                if (!mem_blocks.exists(mem_req.addr)) begin
                    mem_blocks[mem_req.addr] = init_block(mem_req.addr);
                end
                mem_log.push_back(mem_req);
                if (mem_req.write) begin
                    mem_blocks[mem_req.addr] = mem_req.wdata;
                end else begin
                    mem_rdata <= mem_blocks[mem_req.addr];
                end
                mem_ready <= 1'b1;
                // the request is still high at the next edge
                @(posedge clk);
                mem_ready <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (16 + (directed_ops + random_ops) * 40) @(posedge clk);
        $display("watchdog: the requests did not complete in the allowed time");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    initial begin : stimulus
        logic        wr;
        logic [29:0] a;
        rst_n    <= 1'b0;
        proc_req <= '0;
        repeat (16) @(posedge clk);
        check_value("stall in reset", 0, proc_stall);
        check_value("memory read in reset", 0, mem_req.read);
        check_value("memory write in reset", 0, mem_req.write);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("stall after reset", 0, proc_stall);
        // three tags in set 1 are written and then read back through evictions
        for (int n = 0; n < 3; n++) begin
            drive_request(1'b1, {pool_tag(n[1:0]), 2'd1, 2'd2}, 32'hd1e0_0000 + n);
        end
        for (int n = 0; n < 3; n++) begin
            drive_request(1'b0, {pool_tag(n[1:0]), 2'd1, 2'd2}, '0);
        end
        for (int n = 0; n < random_ops; n++) begin
            stim_state = lcg_next(stim_state);
            wr         = stim_state[31];
            a          = {pool_tag(stim_state[27:26]), stim_state[23:22], stim_state[19:18]};
            stim_state = lcg_next(stim_state);
            drive_request(wr, a, stim_state);
        end
        proc_req <= '0;
        @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

/* test/wb_cache_props.sv */
// concurrent port checks for wb_cache, attached to every wb_cache instance by bind
`timescale 1ns/1ns

module wb_cache_props (
    input logic                 clk,
    input logic                 rst_n,
    input cache_pkg::proc_req_t proc_req,
    input logic                 proc_stall,
    input cache_pkg::mem_req_t  mem_req,
    input logic                 hit
);
    // one operation per request on either port
    one_proc_op: assert property (@(posedge clk) disable iff (!rst_n)
        !(proc_req.read && proc_req.write))
        else $error("processor read and write requested together");

    one_mem_op: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req.read && mem_req.write))
        else $error("memory read and write requested together");

    // request held for as long as the cache stalls
    stable_req: assert property (@(posedge clk) disable iff (!rst_n)
        proc_stall |-> $stable(proc_req))
        else $error("processor request changed during a stall");

    // hit: stall high for two samples, low at the third after the request
    hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(proc_stall) && hit |-> ##1 proc_stall ##1 !proc_stall)
        else $error("hit did not complete in 3 cycles");
endmodule

bind wb_cache wb_cache_props i_wb_cache_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .proc_req   (proc_req),
    .proc_stall (proc_stall),
    .mem_req    (mem_req),
    .hit        (hit)
);

/* logic/wb_cache.sv */
// two-way write-back data cache top level; the testbench instances this as the DUT
`timescale 1ns/1ns

module wb_cache (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  cache_pkg::proc_req_t                  proc_req,
    output logic [cache_pkg::word_width-1:0]      proc_rdata,
    output logic                                  proc_stall,
    output cache_pkg::mem_req_t                   mem_req,
    input  logic [cache_pkg::block_width-1:0]     mem_rdata,
    input  logic                                  mem_ready
);
    import cache_pkg::*;

    // ----------------------------------------
    // store answers
    // ----------------------------------------

    logic                        hit;
    logic                        hit_way;
    logic                        victim_way;
    logic                        victim_dirty;
    logic [block_addr_width-1:0] victim_addr;
    logic [block_width-1:0]      victim_block;
    logic [word_width-1:0]       store_rdata;

    // controller commands
    logic                        fill_en;
    logic [block_width-1:0]      fill_data;
    logic                        write_en;
    logic                        way;

    cache_store i_cache_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr         (proc_req.addr),
        .wdata        (proc_req.wdata),
        .fill_en      (fill_en),
        .fill_data    (fill_data),
        .write_en     (write_en),
        .way          (way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_block (victim_block),
        .rdata        (store_rdata)
    );

    cache_ctrl i_cache_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .read         (proc_req.read),
        .write        (proc_req.write),
        .addr         (proc_req.addr),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_block (victim_block),
        .rdata        (store_rdata),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata),
        .proc_stall   (proc_stall),
        .proc_rdata   (proc_rdata),
        .mem_req      (mem_req),
        .fill_en      (fill_en),
        .fill_data    (fill_data),
        .write_en     (write_en),
        .way          (way)
    );

endmodule

/* logic/cache_ctrl.sv */
// write-back cache controller FSM; instanced inside wb_cache next to cache_store
`timescale 1ns/1ns

module cache_ctrl (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   read,
    input  logic                                   write,
    input  logic [cache_pkg::word_addr_width-1:0]  addr,
    input  logic                                   hit,
    input  logic                                   hit_way,
    input  logic                                   victim_way,
    input  logic                                   victim_dirty,
    input  logic [cache_pkg::block_addr_width-1:0] victim_addr,
    input  logic [cache_pkg::block_width-1:0]      victim_block,
    input  logic [cache_pkg::word_width-1:0]       rdata,
    input  logic                                   mem_ready,
    input  logic [cache_pkg::block_width-1:0]      mem_rdata,
    output logic                                   proc_stall,
    output logic [cache_pkg::word_width-1:0]       proc_rdata,
    output cache_pkg::mem_req_t                    mem_req,
    output logic                                   fill_en,
    output logic [cache_pkg::block_width-1:0]      fill_data,
    output logic                                   write_en,
    output logic                                   way
);
    import cache_pkg::*;

    cache_state_e state;

    // high for the cycle after completion, while the old request is still presented
    logic done;

    // registered memory port
    logic                        mem_read;
    logic                        mem_write;
    logic [block_addr_width-1:0] mem_addr;
    logic [block_width-1:0]      mem_wdata;

    // block holding the requested word
    logic [block_addr_width-1:0] req_block;

    assign req_block = addr[word_addr_width-1:offset_width];

    assign mem_req = '{
        read:  mem_read,
        write: mem_write,
        addr:  mem_addr,
        wdata: mem_wdata
    };

    // ----------------------------------------
    // state and control levels
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= idle;
            done       <= 1'b0;
            proc_stall <= 1'b0;
            mem_read   <= 1'b0;
            mem_write  <= 1'b0;
            fill_en    <= 1'b0;
            write_en   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if ((read || write) && !done) begin
                        state      <= compare;
                        proc_stall <= 1'b1;
                    end
                end
                compare: begin
                    if (hit) begin
                        if (write) begin
                            state    <= write_in;
                            write_en <= 1'b1;
                        end else begin
                            state <= read_out;
                        end
                    end else if (victim_dirty) begin
                        state     <= writeback;
                        mem_write <= 1'b1;
                    end else begin
                        state    <= allocate;
                        mem_read <= 1'b1;
                    end
                end
                writeback: begin
                    // victim accepted, go fetch the new block
                    if (mem_ready) begin
                        state     <= allocate;
                        mem_write <= 1'b0;
                        mem_read  <= 1'b1;
                    end
                end
                allocate: begin
                    // second phase: the store loads the block at this edge
                    if (fill_en) begin
                        fill_en <= 1'b0;
                        if (write) begin
                            state    <= write_in;
                            write_en <= 1'b1;
                        end else begin
                            state <= read_out;
                        end
                    end else if (mem_ready) begin
                        mem_read <= 1'b0;
                        fill_en  <= 1'b1;
                    end
                end
                read_out, write_in: begin
                    state      <= idle;
                    proc_stall <= 1'b0;
                    write_en   <= 1'b0;
                    done       <= 1'b1;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // ----------------------------------------
    // payload registers
    // ----------------------------------------

    always_ff @(posedge clk) begin
        case (state)
            compare: begin
                way       <= hit ? hit_way : victim_way;
                mem_addr  <= victim_dirty ? victim_addr : req_block;
                mem_wdata <= victim_block;
            end
            writeback: begin
                if (mem_ready) begin
                    mem_addr <= req_block;
                end
            end
            allocate: begin
                if (!fill_en && mem_ready) begin
                    fill_data <= mem_rdata;
                end
            end
            read_out: begin
                proc_rdata <= rdata;
            end
            default: begin
            end
        endcase
    end

endmodule

/* logic/cache_store.sv */
// tag, status and data arrays of the two-way cache; instanced once inside wb_cache
`timescale 1ns/1ns

module cache_store (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [cache_pkg::word_addr_width-1:0]  addr,
    input  logic [cache_pkg::word_width-1:0]       wdata,
    input  logic                                   fill_en,
    input  logic [cache_pkg::block_width-1:0]      fill_data,
    input  logic                                   write_en,
    input  logic                                   way,
    output logic                                   hit,
    output logic                                   hit_way,
    output logic                                   victim_way,
    output logic                                   victim_dirty,
    output logic [cache_pkg::block_addr_width-1:0] victim_addr,
    output logic [cache_pkg::block_width-1:0]      victim_block,
    output logic [cache_pkg::word_width-1:0]       rdata
);
    import cache_pkg::*;

    // ----------------------------------------
    // storage
    // ----------------------------------------

    logic [block_width-1:0] blocks [way_count][set_count];
    logic [tag_width-1:0]   tags   [way_count][set_count];
    logic [set_count-1:0]   valid  [way_count];
    logic [set_count-1:0]   dirty  [way_count];

    // per set, the way to evict when both are valid
    logic [set_count-1:0]   lru;

    // address fields
    logic [tag_width-1:0]    tag;
    logic [index_width-1:0]  index;
    logic [offset_width-1:0] offset;

    logic [way_count-1:0]    way_hit;

    assign tag    = addr[word_addr_width-1 -: tag_width];
    assign index  = addr[offset_width +: index_width];
    assign offset = addr[offset_width-1:0];

    // ----------------------------------------
    // lookup
    // ----------------------------------------

    always_comb begin
        for (int w = 0; w < way_count; w++) begin
            way_hit[w] = valid[w][index] && (tags[w][index] == tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // fill an empty way first, otherwise the least recently used one
    always_comb begin
        if (!valid[0][index]) begin
            victim_way = 1'b0;
        end else if (!valid[1][index]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru[index];
        end
    end

    // victim block as it must go back to memory
    assign victim_dirty = dirty[victim_way][index];
    assign victim_addr  = {tags[victim_way][index], index};
    assign victim_block = blocks[victim_way][index];

    // word select from the way latched by the controller
    assign rdata = blocks[way][index][offset*word_width +: word_width];

    // ----------------------------------------
    // updates
    // ----------------------------------------

    // block fill replaces data and tag, word write patches one word
    always_ff @(posedge clk) begin
        if (fill_en) begin
            blocks[way][index] <= fill_data;
            tags[way][index]   <= tag;
        end else if (write_en) begin
            blocks[way][index][offset*word_width +: word_width] <= wdata;
        end
    end

    // status bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < way_count; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
            lru <= '0;
        end else if (fill_en) begin
            // fresh block from memory is clean
            valid[way][index] <= 1'b1;
            dirty[way][index] <= 1'b0;
            lru[index]        <= ~way;
        end else if (write_en) begin
            dirty[way][index] <= 1'b1;
            lru[index]        <= ~way;
        end
    end

endmodule

/* logic/cache_pkg.sv */
// shared cache geometry, port structs and controller states; compile before the RTL files

package cache_pkg;

    // ----------------------------------------
    // geometry
    // ----------------------------------------

    // processor side words
    localparam int word_width      = 32;
    localparam int words_per_block = 4;
    localparam int block_width     = word_width * words_per_block;

    // two ways of four sets
    localparam int set_count = 4;
    localparam int way_count = 2;

    // address widths on both ports
    localparam int word_addr_width  = 30;
    localparam int block_addr_width = 28;

    // word address split: tag | index | offset
    localparam int index_width  = 2;
    localparam int offset_width = 2;
    localparam int tag_width    = word_addr_width - index_width - offset_width;

    // ----------------------------------------
    // port bundles
    // ----------------------------------------

    // processor request, held stable until stall drops
    typedef struct packed {
        logic                       read;
        logic                       write;
        logic [word_addr_width-1:0] addr;
        logic [word_width-1:0]      wdata;
    } proc_req_t;

    // memory request, levels held until mem_ready
    typedef struct packed {
        logic                        read;
        logic                        write;
        logic [block_addr_width-1:0] addr;
        logic [block_width-1:0]      wdata;
    } mem_req_t;

    // ----------------------------------------
    // controller
    // ----------------------------------------

    typedef enum logic [2:0] {
        idle,
        compare,
        writeback,
        allocate,
        read_out,
        write_in
    } cache_state_e;

endpackage
